// File: rtl/arbFixed.sv
// Combinational fixed-priority arbiter where the lowest request index wins
`timescale 1ns/1ns

module arbFixed
  import flowMuxPkg::*;
(
  input  logic [NumFlows-1:0] request,
  output logic [NumFlows-1:0] canGrant,
  output logic [NumFlows-1:0] grant
);

  // ----------------------------------------------------------------------
  // Prefix OR of lower-index requests
  // ----------------------------------------------------------------------

  // Bit i is set when any flow below i requests
  logic [NumFlows-1:0] lowerRequest;

  always_comb begin
    // Flow 0 has nothing above it in priority
    lowerRequest[0] = 1'b0;
    for (int i = 1; i < NumFlows; i++) begin
      lowerRequest[i] = lowerRequest[i-1] | request[i-1];
    end
  end

  // ----------------------------------------------------------------------
  // Allow and grant
  // ----------------------------------------------------------------------

  // A flow may win only if nobody with higher priority asks
  assign canGrant = ~lowerRequest;

  // Masking keeps at most one bit set
  // Zero when no flow requests
  assign grant = request & canGrant;

endmodule : arbFixed

// File: rtl/flowIf.sv
// Ready/valid tagged flow bundle between the flow mux and the output slice
`timescale 1ns/1ns

interface flowIf
  import flowMuxPkg::*;
();

  // Handshake pair
  // A word moves on a rising clk edge with both high
  logic valid;
  logic ready;

  // Payload and the index of the flow it belongs to
  flowData_t data;
  flowId_t flowId;

  // Producer side
  modport source (
    output valid,
    output data,
    output flowId,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  data,
    input  flowId,
    output ready
  );

endinterface : flowIf

// File: rtl/flowMuxCore.sv
// Flow mux datapath that turns arbiter grants into a tagged pop flow
`timescale 1ns/1ns

module flowMuxCore
  import flowMuxPkg::*;
(
  // Not used by this fixed-priority core
  // Kept so stateful arbiter variants can share the same port list
  input  logic                     clk,
  input  logic                     rst,

  // Arbiter side
  output logic [NumFlows-1:0]      request,
  input  logic [NumFlows-1:0]      canGrant,
  input  logic [NumFlows-1:0]      grant,

  // Push side, one handshake per flow
  input  logic [NumFlows-1:0]      pushValid,
  output logic [NumFlows-1:0]      pushReady,
  input  flowData_t [NumFlows-1:0] pushData,

  // Pop side toward the output slice
  flowIf.source                    pop
);

  // ----------------------------------------------------------------------
  // Requests and pop valid
  // ----------------------------------------------------------------------

  // Every valid flow asks for the output
  assign request = pushValid;

  // The lowest active flow always has canGrant set
  // So this reduces to the OR of all push valids
  assign pop.valid = |(pushValid & canGrant);

  // ----------------------------------------------------------------------
  // Data select and flow tag
  // ----------------------------------------------------------------------

  // Grant is one-hot or zero, so at most one branch fires
  // Data and tag may change while the slice stalls
  always_comb begin
    pop.data   = '0;
    pop.flowId = '0;
    for (int i = 0; i < NumFlows; i++) begin
      if (grant[i]) begin
        pop.data   = pushData[i];
        pop.flowId = flowId_t'(i);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Push ready
  // ----------------------------------------------------------------------

  // Only the winner sees ready, and only when the slice can take a word
  assign pushReady = grant & {NumFlows{pop.ready}};

endmodule : flowMuxCore

// File: rtl/flowMuxFixed.sv
// Fixed-priority flow mux joining the arbiter and the mux datapath, no delay
`timescale 1ns/1ns

module flowMuxFixed
  import flowMuxPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,

  // Producer flows
  input  logic [NumFlows-1:0]      pushValid,
  output logic [NumFlows-1:0]      pushReady,
  input  flowData_t [NumFlows-1:0] pushData,

  // Granted flow with its tag
  // Valid may drop and data may switch while ready is low
  flowIf.source                    pop
);

  // ----------------------------------------------------------------------
  // Arbiter to core wiring
  // ----------------------------------------------------------------------

  logic [NumFlows-1:0] request;
  logic [NumFlows-1:0] canGrant;
  logic [NumFlows-1:0] grant;

  // Strict priority, flow 0 highest
  arbFixed arb (
    .request  (request),
    .canGrant (canGrant),
    .grant    (grant)
  );

  // ----------------------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------------------

  // Steers the granted word and closes the push handshake
  flowMuxCore core (
    .clk       (clk),
    .rst       (rst),
    .request   (request),
    .canGrant  (canGrant),
    .grant     (grant),
    .pushValid (pushValid),
    .pushReady (pushReady),
    .pushData  (pushData),
    .pop       (pop)
  );

endmodule : flowMuxFixed

// File: rtl/flowMuxPkg.sv
// Flow mux package with shared sizes, payload types and slice state encoding
package flowMuxPkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------

  // Number of producer flows feeding the mux
  localparam int NumFlows = 4;

  // Payload word width
  localparam int DataWidth = 16;

  // Enough bits to index every flow
  localparam int FlowIdWidth = 2;

  // ----------------------------------------------------------------------
  // Types
  // ----------------------------------------------------------------------

  // One payload word
  typedef logic [DataWidth-1:0] flowData_t;

  // Index of the flow a word came from
  typedef logic [FlowIdWidth-1:0] flowId_t;

  // Occupancy of the output register slice
  typedef enum logic [1:0] {
    sliceEmpty = 2'd0,  // nothing held, output invalid
    sliceOne   = 2'd1,  // main entry holds the output word
    sliceFull  = 2'd2   // main and skid entries both hold a word
  } sliceState_t;

endpackage : flowMuxPkg

// File: rtl/flowMuxTop.sv
// Top level of the fixed-priority flow mux with a registered output slice
`timescale 1ns/1ns

module flowMuxTop
  import flowMuxPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,

  // ----------------------------------------------------------------------
  // Push side, one ready/valid pair per flow
  // ----------------------------------------------------------------------
  input  logic [NumFlows-1:0]      pushValid,
  output logic [NumFlows-1:0]      pushReady,
  input  flowData_t [NumFlows-1:0] pushData,

  // ----------------------------------------------------------------------
  // Pop side, stable under back-pressure
  // ----------------------------------------------------------------------
  output logic                     popValid,
  input  logic                     popReady,
  output flowData_t                popData,
  output flowId_t                  popFlowId
);

  // Mux to slice link
  flowIf muxToSlice ();

  // Zero-delay arbitration and steering
  flowMuxFixed mux (
    .clk       (clk),
    .rst       (rst),
    .pushValid (pushValid),
    .pushReady (pushReady),
    .pushData  (pushData),
    .pop       (muxToSlice.source)
  );

  // One cycle of latency, output held while popReady is low
  flowRegSlice slice (
    .clk       (clk),
    .rst       (rst),
    .in        (muxToSlice.sink),
    .outValid  (popValid),
    .outReady  (popReady),
    .outData   (popData),
    .outFlowId (popFlowId)
  );

endmodule : flowMuxTop

// File: rtl/flowRegSlice.sv
// Two-entry register slice giving a stable full-throughput ready/valid output
`timescale 1ns/1ns

module flowRegSlice
  import flowMuxPkg::*;
(
  input  logic      clk,
  input  logic      rst,

  // Unstable tagged flow from the mux
  flowIf.sink       in,

  // Registered output
  output logic      outValid,
  input  logic      outReady,
  output flowData_t outData,
  output flowId_t   outFlowId
);

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------

  sliceState_t state;

  // Main entry drives the output directly
  flowData_t mainData;
  flowId_t   mainId;

  // Skid entry catches the word that arrives during a stall
  flowData_t skidData;
  flowId_t   skidId;

  logic inXfer;
  logic outXfer;

  // Ready comes from the state register only
  // No combinational path from outReady back to the mux
  assign in.ready = (state != sliceFull);

  assign outValid  = (state != sliceEmpty);
  assign outData   = mainData;
  assign outFlowId = mainId;

  assign inXfer  = in.valid & in.ready;
  assign outXfer = outValid & outReady;

  // ----------------------------------------------------------------------
  // Occupancy FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= sliceEmpty;
    end else begin
      case (state)
        sliceEmpty: if (inXfer) state <= sliceOne;
        // Simultaneous push and pop keeps one word in flight
        sliceOne: begin
          if (inXfer && !outXfer) begin
            state <= sliceFull;
          end else if (!inXfer && outXfer) begin
            state <= sliceEmpty;
          end
        end
        // Input is blocked here, only the output can drain
        sliceFull: if (outXfer) state <= sliceOne;
        default: state <= sliceEmpty;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Payload registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    // Load main when it is empty or being popped this edge
    if (state == sliceFull) begin
      if (outXfer) begin
        mainData <= skidData;
        mainId   <= skidId;
      end
    end else if (inXfer && (state == sliceEmpty || outXfer)) begin
      mainData <= in.data;
      mainId   <= in.flowId;
    end
    // Stalled with one word held, park the newcomer
    if (state == sliceOne && inXfer && !outXfer) begin
      skidData <= in.data;
      skidId   <= in.flowId;
    end
  end

endmodule : flowRegSlice

// File: run.sh
#!/usr/bin/env bash
# Build and run the flow mux testbench with Verilator
# Exit status is nonzero when the simulation fails

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -j 0 \
    --top-module flowMuxTb -f sources.f &&
  ./obj_dir/VflowMuxTb ||
  { echo "Build or simulation failed"; exit 1; }

// File: sources.f
rtl/flowMuxPkg.sv
rtl/flowIf.sv
rtl/arbFixed.sv
rtl/flowMuxCore.sv
rtl/flowMuxFixed.sv
rtl/flowRegSlice.sv
rtl/flowMuxTop.sv
tests/flowMuxTb.sv

// File: tests/flowMuxTb.sv
// Testbench for the fixed-priority flow mux with random traffic, scoreboard and assertions
`timescale 1ns/1ns

module flowMuxTb
  import flowMuxPkg::*;
();

  // ----------------------------------------------------------------------
  // Test sizes and run limit
  // ----------------------------------------------------------------------

  localparam int WordsPerFlow  = 60;
  // Tail of flow 0 that is sent back to back with popReady held high
  localparam int StreamWords   = 20;
  localparam int TimeoutCycles = 20 * NumFlows * WordsPerFlow;

  logic                     clk;
  logic                     rst;
  logic [NumFlows-1:0]      pushValid;
  logic [NumFlows-1:0]      pushReady;
  flowData_t [NumFlows-1:0] pushData;
  logic                     popValid;
  logic                     popReady;
  flowData_t                popData;
  flowId_t                  popFlowId;

  // Expected words per flow with the oldest at the front
  flowData_t expQ[NumFlows][$];
  int offered[NumFlows];
  logic [NumFlows-1:0] fire = '0;
  logic [15:0] lfsr = 16'd31380;
  logic streamCheck = 1'b0;
  int cycleCount = 0;

  flowMuxTop uut (
    .clk       (clk),
    .rst       (rst),
    .pushValid (pushValid),
    .pushReady (pushReady),
    .pushData  (pushData),
    .popValid  (popValid),
    .popReady  (popReady),
    .popData   (popData),
    .popFlowId (popFlowId)
  );

  always #2 clk = ~clk;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  task automatic abortRun(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "Run stopped on the first error");
  endtask

  // Fibonacci LFSR for x^16 + x^14 + x^13 + x^11 + 1 shifting right
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
  endfunction

  // One LFSR step per bit taken
  task automatic randBits(input int n, output logic [15:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[14:0], lfsr[15]};
    end
  endtask

  function automatic int randomPhaseWords(input int i);
    return (i == 0) ? WordsPerFlow - StreamWords : WordsPerFlow;
  endfunction

  function automatic logic queuesEmpty();
    for (int i = 0; i < NumFlows; i++) begin
      if (expQ[i].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic logic randomPhaseDone();
    for (int i = 0; i < NumFlows; i++) begin
      if (offered[i] < randomPhaseWords(i)) return 1'b0;
    end
    return (pushValid == '0) && queuesEmpty();
  endfunction

  // Word holds the sequence number, the flow index and a random byte
  task automatic offerWord(input int i);
    logic [15:0] r;
    randBits(8, r);
    pushData[i] = {6'(offered[i]), flowId_t'(i), r[7:0]};
    pushValid[i] = 1'b1;
    offered[i]++;
  endtask

  // Sampled mid-cycle, so these are the values at the coming edge
  // Pops go first so a word pushed at this edge cannot already be on pop
  task automatic recordEdge();
    flowData_t head;
    fire = pushValid & pushReady;
    if (popValid && popReady) begin
      assert (expQ[popFlowId].size() != 0)
        else abortRun($sformatf("FAIL at %0t: pop on flow %0d with no word outstanding",
                                $time, popFlowId));
      head = expQ[popFlowId].pop_front();
      assert (popData == head)
        else abortRun($sformatf("FAIL at %0t: flow %0d popped %h, expected %h",
                                $time, popFlowId, popData, head));
    end
    for (int i = 0; i < NumFlows; i++) begin
      if (fire[i]) begin
        expQ[i].push_back(pushData[i]);
      end
    end
  endtask

  // Idle or just accepted flows may offer a new word
  // popReady is low on about 40% of cycles
  task automatic driveRandom();
    logic [15:0] r;
    for (int i = 0; i < NumFlows; i++) begin
      if (fire[i]) pushValid[i] = 1'b0;
      if (!pushValid[i] && offered[i] < randomPhaseWords(i)) begin
        randBits(1, r);
        if (r[0]) offerWord(i);
      end
    end
    randBits(5, r);
    popReady = (r[4:0] >= 5'd13);
  endtask

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  // Covers every reset edge after the first and the edge right after release
  assert property (@(posedge clk) $past(rst) |-> !popValid)
    else abortRun($sformatf("FAIL at %0t: popValid high in or right after reset", $time));

  assert property (@(posedge clk) disable iff (rst) $onehot0(pushReady))
    else abortRun($sformatf("FAIL at %0t: more than one pushReady high", $time));

  // No lower-index flow may be waiting when a flow is accepted
  assert property (@(posedge clk) disable iff (rst)
      (|pushReady) |-> ((pushValid & (pushReady - NumFlows'(1))) == '0))
    else abortRun($sformatf("FAIL at %0t: flow accepted over a lower-index request", $time));

  assert property (@(posedge clk) disable iff (rst)
      (popValid && !popReady) |=> (popValid && $stable(popData) && $stable(popFlowId)))
    else abortRun($sformatf("FAIL at %0t: pop output changed during a stall", $time));

  // One word in and one word out on every streaming edge
  assert property (@(posedge clk) disable iff (rst)
      streamCheck |-> (popValid && popReady && pushValid[0] && pushReady[0]))
    else abortRun($sformatf("FAIL at %0t: stream lost a cycle of throughput", $time));

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      abortRun($sformatf("Timeout after %0d cycles, words stopped moving", cycleCount));
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    pushValid = '0;
    pushData = '0;
    popReady = 1'b0;
    for (int i = 0; i < NumFlows; i++) begin
      offered[i] = 0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // Random traffic on all flows with back-pressure
    driveRandom();
    while (!randomPhaseDone()) begin
      @(negedge clk);
      recordEdge();
      @(posedge clk);
      #1;
      driveRandom();
    end

    // Flow 0 streams into an empty slice
    popReady = 1'b1;
    for (int k = 0; k < StreamWords; k++) begin
      offerWord(0);
      streamCheck = (k != 0);
      @(negedge clk);
      recordEdge();
      @(posedge clk);
      #1;
    end
    pushValid[0] = 1'b0;
    streamCheck = 1'b0;

    // Drain what is left in the slice
    while (!queuesEmpty()) begin
      @(negedge clk);
      recordEdge();
      @(posedge clk);
      #1;
    end

    // Every pushed word has left, so the slice must now be empty
    if (popValid) begin
      abortRun($sformatf("FAIL at %0t: popValid high with no word outstanding", $time));
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule : flowMuxTb
